// File: hdl/usb_bridge_pkg.sv
// Bridge package with widths, command codes, byte markers and the USB byte layout
package usb_bridge_pkg;

	// ------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------

	// One FT245 bus byte
	localparam int BYTE_W = 8;
	// Endpoint address inside a control byte
	localparam int ADDR_W = 3;

	// ------------------------------------------------------------
	// Commands and markers
	// ------------------------------------------------------------

	// Any code not listed here is unknown and gets dropped
	typedef enum logic [2:0] {
		CMD_TRIGGER  = 3'd1,
		CMD_TRANSFER = 3'd2
	} cmd_e;

	// Top two bits of a control byte from the host
	localparam logic [1:0] MARK_TO_DEVICE = 2'b10;
	// Top two bits of a header byte toward the host
	localparam logic [1:0] MARK_TO_HOST   = 2'b11;

	// ------------------------------------------------------------
	// USB byte layout
	// ------------------------------------------------------------

	// Control view, marker in the MSBs
	typedef struct packed {
		logic [1:0]        marker;
		cmd_e              cmd;
		logic [ADDR_W-1:0] addr;
	} usb_ctrl_t;

	// Same bus byte seen raw or as control fields
	typedef union packed {
		logic [BYTE_W-1:0] raw;
		usb_ctrl_t         ctrl;
	} usb_byte_u;

endpackage

// File: hdl/usb_byte_if.sv
// Byte interface between the FT245 pin controller and the protocol blocks
`timescale 1ns/1ps

interface usb_byte_if
	import usb_bridge_pkg::*;
();

	// Received byte from the host, one-cycle strobe
	logic              rx_strobe;
	logic [BYTE_W-1:0] rx_byte;

	// Byte toward the host, latched by the port on tx_strobe
	logic              tx_strobe;
	logic [BYTE_W-1:0] tx_byte;
	// Write cycle of the last byte finished
	logic              tx_done;

	// Pin controller side
	modport port (
		output rx_strobe,
		output rx_byte,
		output tx_done,
		input  tx_strobe,
		input  tx_byte
	);

	// Host command decoder only listens
	modport decoder (
		input rx_strobe,
		input rx_byte
	);

	// Device message encoder
	modport encoder (
		output tx_strobe,
		output tx_byte,
		input  tx_done
	);

endinterface

// File: hdl/ft245_port.sv
// FT245 pin controller running read and write cycles on the shared tristate bus
`timescale 1ns/1ps

module ft245_port
	import usb_bridge_pkg::*;
#(
	parameter int RD_PULSE_CYCLES = 2,
	parameter int WR_PULSE_CYCLES = 2
)
(
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              usb_rxf_n,
	input  logic              usb_txe_n,
	output logic              usb_rd_n,
	output logic              usb_wr_n,
	inout  wire  [BYTE_W-1:0] usb_data,
	usb_byte_if.port          bus
);

	// Counter sized for the longer strobe
	localparam int MAX_PULSE = (RD_PULSE_CYCLES > WR_PULSE_CYCLES) ?
		RD_PULSE_CYCLES : WR_PULSE_CYCLES;
	localparam int CNT_W = $clog2(MAX_PULSE + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RD_LOW,
		ST_RD_END,
		ST_WR_LOW,
		ST_WR_END
	} port_state_e;

	port_state_e       state;
	logic [CNT_W-1:0]  pulse_cnt;

	// Synchronized status pins
	logic              rxf_meta;
	logic              rxf_sync;
	logic              txe_meta;
	logic              txe_sync;

	// Read rearm after rxf_n went high
	logic              rd_armed;

	// One byte waiting for a write cycle
	logic              tx_pending;
	logic [BYTE_W-1:0] tx_hold;

	logic              bus_oe;
	logic              start_write;
	logic              start_read;

	// ------------------------------------------------------------
	// Status pin synchronizers
	// ------------------------------------------------------------

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			// Both pins idle high
			rxf_meta <= 1'b1;
			rxf_sync <= 1'b1;
			txe_meta <= 1'b1;
			txe_sync <= 1'b1;
		end
		else
		begin
			rxf_meta <= usb_rxf_n;
			rxf_sync <= rxf_meta;
			txe_meta <= usb_txe_n;
			txe_sync <= txe_meta;
		end
	end

	// ------------------------------------------------------------
	// Arbitration
	// ------------------------------------------------------------

	// Writes win, a running cycle always finishes first
	assign start_write = (state == ST_IDLE) && tx_pending && !txe_sync;
	assign start_read  = (state == ST_IDLE) && !start_write && rd_armed && !rxf_sync;

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			rd_armed   <= 1'b1;
			tx_pending <= 1'b0;
		end
		else
		begin
			// Next read only after rxf_n was seen high again
			if (start_read)
				rd_armed <= 1'b0;
			else if (rxf_sync)
				rd_armed <= 1'b1;

			// Held through any txe_n stall
			if (bus.tx_strobe)
				tx_pending <= 1'b1;
			else if (state == ST_WR_END)
				tx_pending <= 1'b0;
		end
	end

	// Byte storage
	always_ff @(posedge CLK)
	begin
		if (bus.tx_strobe)
			tx_hold <= bus.tx_byte;
		// Sample on the last rd_n low cycle
		if (state == ST_RD_LOW && pulse_cnt == '0)
			bus.rx_byte <= usb_data;
	end

	// ------------------------------------------------------------
	// Read and write cycle FSM
	// ------------------------------------------------------------

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			state         <= ST_IDLE;
			pulse_cnt     <= '0;
			usb_rd_n      <= 1'b1;
			usb_wr_n      <= 1'b1;
			bus_oe        <= 1'b0;
			bus.rx_strobe <= 1'b0;
			bus.tx_done   <= 1'b0;
		end
		else
		begin
			// Strobes last a single cycle
			bus.rx_strobe <= 1'b0;
			bus.tx_done   <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (start_write)
					begin
						bus_oe    <= 1'b1;
						usb_wr_n  <= 1'b0;
						pulse_cnt <= CNT_W'(WR_PULSE_CYCLES - 1);
						state     <= ST_WR_LOW;
					end
					else if (start_read)
					begin
						usb_rd_n  <= 1'b0;
						pulse_cnt <= CNT_W'(RD_PULSE_CYCLES - 1);
						state     <= ST_RD_LOW;
					end
				end
				ST_RD_LOW:
				begin
					if (pulse_cnt == '0)
					begin
						usb_rd_n <= 1'b1;
						state    <= ST_RD_END;
					end
					else
						pulse_cnt <= pulse_cnt - CNT_W'(1);
				end
				ST_RD_END:
				begin
					// Byte handed over one cycle after rd_n rose
					bus.rx_strobe <= 1'b1;
					state         <= ST_IDLE;
				end
				ST_WR_LOW:
				begin
					if (pulse_cnt == '0)
					begin
						usb_wr_n <= 1'b1;
						state    <= ST_WR_END;
					end
					else
						pulse_cnt <= pulse_cnt - CNT_W'(1);
				end
				ST_WR_END:
				begin
					// Hold time after wr_n rise then let go
					bus_oe      <= 1'b0;
					bus.tx_done <= 1'b1;
					state       <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Bus driven only during a write cycle
	assign usb_data = bus_oe ? tx_hold : {BYTE_W{1'bz}};

endmodule

// File: hdl/host_cmd_decoder.sv
// Host command decoder pairing control and data bytes into device strobes
`timescale 1ns/1ps

module host_cmd_decoder
	import usb_bridge_pkg::*;
(
	input  logic              CLK,
	input  logic              RST_N,
	usb_byte_if.decoder       bus,
	output logic              dev_strobe,
	output cmd_e              dev_cmd,
	output logic [ADDR_W-1:0] dev_addr,
	output logic [BYTE_W-1:0] dev_data
);

	typedef enum logic {
		DEC_CTRL,
		DEC_DATA
	} dec_state_e;

	dec_state_e        dec_state;
	usb_byte_u         rx_word;

	// Fields held from the control byte
	cmd_e              cmd_q;
	logic [ADDR_W-1:0] addr_q;

	logic              ctrl_hit;
	logic              pair_ok;

	always_comb
	begin
		rx_word.raw = bus.rx_byte;
	end

	// Marked control byte while waiting for one
	assign ctrl_hit = bus.rx_strobe && (dec_state == DEC_CTRL) &&
		(rx_word.ctrl.marker == MARK_TO_DEVICE);

	// Data byte closing a pair with a known command
	assign pair_ok = bus.rx_strobe && (dec_state == DEC_DATA) &&
		((cmd_q == CMD_TRIGGER) || (cmd_q == CMD_TRANSFER));

	// ------------------------------------------------------------
	// Pair tracking and strobe
	// ------------------------------------------------------------

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			dec_state  <= DEC_CTRL;
			dev_strobe <= 1'b0;
		end
		else
		begin
			dev_strobe <= pair_ok;
			if (ctrl_hit)
				dec_state <= DEC_DATA;
			// Unknown commands still consume their data byte
			else if (bus.rx_strobe && dec_state == DEC_DATA)
				dec_state <= DEC_CTRL;
		end
	end

	// Field registers
	always_ff @(posedge CLK)
	begin
		if (ctrl_hit)
		begin
			cmd_q  <= rx_word.ctrl.cmd;
			addr_q <= rx_word.ctrl.addr;
		end
		if (pair_ok)
		begin
			dev_cmd  <= cmd_q;
			// Trigger has no endpoint
			dev_addr <= (cmd_q == CMD_TRIGGER) ? '0 : addr_q;
			dev_data <= rx_word.raw;
		end
	end

endmodule

// File: hdl/device_msg_encoder.sv
// Device message encoder sending a header and payload byte pair to the host
`timescale 1ns/1ps

module device_msg_encoder
	import usb_bridge_pkg::*;
(
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              host_req,
	input  cmd_e              host_cmd,
	input  logic [ADDR_W-1:0] host_addr,
	input  logic [BYTE_W-1:0] host_data,
	output logic              busy,
	usb_byte_if.encoder       bus
);

	typedef enum logic [1:0] {
		ENC_IDLE,
		ENC_HEADER,
		ENC_PAYLOAD
	} enc_state_e;

	enc_state_e        enc_state;

	// Latched request
	cmd_e              cmd_q;
	logic [ADDR_W-1:0] addr_q;
	logic [BYTE_W-1:0] data_q;

	usb_byte_u         hdr;
	logic              req_ok;

	// Known commands only, nothing taken while busy
	assign req_ok = host_req && !busy &&
		((host_cmd == CMD_TRIGGER) || (host_cmd == CMD_TRANSFER));

	// ------------------------------------------------------------
	// Message sequencing
	// ------------------------------------------------------------

	always_ff @(posedge CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			enc_state     <= ENC_IDLE;
			bus.tx_strobe <= 1'b0;
		end
		else
		begin
			bus.tx_strobe <= 1'b0;
			case (enc_state)
				ENC_IDLE:
				begin
					// Header goes out together with busy
					if (req_ok)
					begin
						bus.tx_strobe <= 1'b1;
						enc_state     <= ENC_HEADER;
					end
				end
				ENC_HEADER:
				begin
					// Payload right after the header write
					if (bus.tx_done)
					begin
						bus.tx_strobe <= 1'b1;
						enc_state     <= ENC_PAYLOAD;
					end
				end
				ENC_PAYLOAD:
				begin
					if (bus.tx_done)
						enc_state <= ENC_IDLE;
				end
				default:
					enc_state <= ENC_IDLE;
			endcase
		end
	end

	// Request fields
	always_ff @(posedge CLK)
	begin
		if (req_ok)
		begin
			cmd_q  <= host_cmd;
			// Trigger always reports address 0
			addr_q <= (host_cmd == CMD_TRIGGER) ? '0 : host_addr;
			data_q <= host_data;
		end
	end

	// Header from the control view
	always_comb
	begin
		hdr.ctrl.marker = MARK_TO_HOST;
		hdr.ctrl.cmd    = cmd_q;
		hdr.ctrl.addr   = addr_q;
	end

	// Byte offered matches the strobe in flight
	assign bus.tx_byte = (enc_state == ENC_HEADER) ? hdr.raw : data_q;

	// High from header strobe until after the payload tx_done
	assign busy = (enc_state != ENC_IDLE);

endmodule

// File: hdl/usb_fifo_bridge.sv
// Top level of the FT245 USB FIFO to device byte bridge
`timescale 1ns/1ps

module usb_fifo_bridge
	import usb_bridge_pkg::*;
#(
	parameter int RD_PULSE_CYCLES = 2,
	parameter int WR_PULSE_CYCLES = 2
)
(
	input  logic              CLK,
	input  logic              RST_N,

	// FT245 pins
	input  logic              usb_rxf_n,
	input  logic              usb_txe_n,
	output logic              usb_rd_n,
	output logic              usb_wr_n,
	inout  wire  [BYTE_W-1:0] usb_data,

	// Strobe toward the device
	output logic              dev_strobe,
	output cmd_e              dev_cmd,
	output logic [ADDR_W-1:0] dev_addr,
	output logic [BYTE_W-1:0] dev_data,

	// Request from the device
	input  logic              host_req,
	input  cmd_e              host_cmd,
	input  logic [ADDR_W-1:0] host_addr,
	input  logic [BYTE_W-1:0] host_data,
	output logic              busy
);

	// ------------------------------------------------------------
	// Internal byte bus
	// ------------------------------------------------------------

	usb_byte_if byte_bus ();

	// Pin side
	ft245_port #(
		.RD_PULSE_CYCLES (RD_PULSE_CYCLES),
		.WR_PULSE_CYCLES (WR_PULSE_CYCLES)
	) u_port (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.usb_rxf_n (usb_rxf_n),
		.usb_txe_n (usb_txe_n),
		.usb_rd_n  (usb_rd_n),
		.usb_wr_n  (usb_wr_n),
		.usb_data  (usb_data),
		.bus       (byte_bus.port)
	);

	// Host to device path
	host_cmd_decoder u_decoder (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.bus        (byte_bus.decoder),
		.dev_strobe (dev_strobe),
		.dev_cmd    (dev_cmd),
		.dev_addr   (dev_addr),
		.dev_data   (dev_data)
	);

	// Device to host path
	device_msg_encoder u_encoder (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.host_req  (host_req),
		.host_cmd  (host_cmd),
		.host_addr (host_addr),
		.host_data (host_data),
		.busy      (busy),
		.bus       (byte_bus.encoder)
	);

endmodule

// File: sim/ft245_chip_model.sv
// Behavioral FT245 chip with a receive queue, a transmit log and TXE stalls
`timescale 1ns/1ps

module ft245_chip_model
(
	input  logic       CLK,
	input  logic       RST_N,
	output logic       usb_rxf_n,
	output logic       usb_txe_n,
	input  logic       usb_rd_n,
	input  logic       usb_wr_n,
	inout  wire  [7:0] usb_data
);

	// Bytes from the host waiting to be read
	logic [7:0] rx_mem [0:1023];
	int         rx_wr = 0;
	int         rx_rd = 0;

	// Bytes the bridge wrote toward the host
	logic [7:0] log_mem [0:1023];
	int         log_count = 0;

	// Free running cycle count for TXE stalls
	longint     cycle_cnt = 0;
	longint     txe_until = 0;

	// ------------------------------------------------------------
	// Calls from the testbench
	// ------------------------------------------------------------

	// Queue one host byte
	task automatic push_byte(input logic [7:0] b);
		rx_mem[rx_wr] = b;
		rx_wr = rx_wr + 1;
	endtask

	// Chip full for the given number of cycles
	task automatic hold_txe(input int cycles);
		txe_until = cycle_cnt + cycles;
	endtask

	// ------------------------------------------------------------
	// Pin behavior
	// ------------------------------------------------------------

	// Empty queue or read in progress keeps rxf_n high
	assign usb_rxf_n = (rx_rd == rx_wr) || (usb_rd_n === 1'b0);

	// Head byte on the bus only while rd_n is low
	assign usb_data = (usb_rd_n === 1'b0) ? rx_mem[rx_rd] : 8'bz;

	// Byte consumed when the read strobe ends
	always @(posedge usb_rd_n)
	begin
		if (RST_N === 1'b1)
			rx_rd <= rx_rd + 1;
	end

	// Capture on the rising edge of wr_n
	always @(posedge usb_wr_n)
	begin
		if (RST_N === 1'b1)
		begin
			log_mem[log_count] = usb_data;
			log_count = log_count + 1;
		end
	end

	always @(posedge CLK)
		cycle_cnt <= cycle_cnt + 1;

	assign usb_txe_n = (cycle_cnt < txe_until);

endmodule

// File: sim/tb_usb_fifo_bridge.sv
// Testbench for the USB FIFO bridge, driven by records from a test file
`timescale 1ns/1ps

module tb_usb_fifo_bridge
	import usb_bridge_pkg::*;
();

	logic       CLK;
	logic       RST_N;
	wire        usb_rxf_n;
	wire        usb_txe_n;
	wire        usb_rd_n;
	wire        usb_wr_n;
	wire  [7:0] usb_data;
	logic       dev_strobe;
	cmd_e       dev_cmd;
	logic [2:0] dev_addr;
	logic [7:0] dev_data;
	logic       host_req;
	cmd_e       host_cmd;
	logic [2:0] host_addr;
	logic [7:0] host_data;
	logic       busy;

	// Parsed test records
	logic [7:0] rec_kind [0:63];
	int         rec_f [0:63][0:8];
	int         n_rec = 0;
	logic       tests_loaded = 1'b0;

	// Every dev_strobe seen, in order
	logic [2:0] got_cmd  [0:255];
	logic [2:0] got_addr [0:255];
	logic [7:0] got_data [0:255];
	int         strobe_count = 0;

	int          errors = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	logic [31:0] rand_state = 32'd21119;

	usb_fifo_bridge DUT (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.usb_rxf_n  (usb_rxf_n),
		.usb_txe_n  (usb_txe_n),
		.usb_rd_n   (usb_rd_n),
		.usb_wr_n   (usb_wr_n),
		.usb_data   (usb_data),
		.dev_strobe (dev_strobe),
		.dev_cmd    (dev_cmd),
		.dev_addr   (dev_addr),
		.dev_data   (dev_data),
		.host_req   (host_req),
		.host_cmd   (host_cmd),
		.host_addr  (host_addr),
		.host_data  (host_data),
		.busy       (busy)
	);

	ft245_chip_model chip (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.usb_rxf_n (usb_rxf_n),
		.usb_txe_n (usb_txe_n),
		.usb_rd_n  (usb_rd_n),
		.usb_wr_n  (usb_wr_n),
		.usb_data  (usb_data)
	);

	// 40 ns clock
	initial
		CLK = 1'b0;
	always #20 CLK = ~CLK;

	// Strobes sampled mid cycle
	always @(negedge CLK)
	begin
		if (RST_N && dev_strobe)
		begin
			got_cmd[strobe_count]  = dev_cmd;
			got_addr[strobe_count] = dev_addr;
			got_data[strobe_count] = dev_data;
			strobe_count = strobe_count + 1;
		end
	end

	// Run limit from the number of records
	initial
	begin
		wait (tests_loaded);
		repeat (n_rec * 400) @(posedge CLK);
		$display("ERROR: watchdog expired before the tests finished");
		$display("Something failed");
		$finish;
	end

	// ------------------------------------------------------------
	// Checks and helpers
	// ------------------------------------------------------------

	task automatic compare_hex(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp === act)
		else
		begin
			$display("MISMATCH %s expected %0h got %0h", name, exp, act);
			errors = errors + 1;
		end
	endtask

	task automatic confirm(input logic cond, input string what);
		assert (cond === 1'b1)
		else
		begin
			$display("ERROR: %s", what);
			errors = errors + 1;
		end
	endtask

	// LCG step, upper bits are the better ones
	function automatic logic [7:0] rand_byte();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state[23:16];
	endfunction

	// One device request, driven after the edge
	task automatic send_request(input logic [2:0] c, input logic [2:0] a,
		input logic [7:0] d);
		@(posedge CLK);
		#2;
		host_req  = 1'b1;
		host_cmd  = cmd_e'(c);
		host_addr = a;
		host_data = d;
		@(posedge CLK);
		#2;
		host_req  = 1'b0;
	endtask

	task automatic wait_not_busy();
		int waited;
		waited = 0;
		while (busy !== 1'b0 && waited < 200)
		begin
			@(negedge CLK);
			waited++;
		end
		confirm(busy === 1'b0, "busy never dropped");
	endtask

	// All host bytes read, then room for late strobes
	task automatic drain_and_settle();
		int waited;
		waited = 0;
		while (chip.rx_rd != chip.rx_wr && waited < 300)
		begin
			@(posedge CLK);
			waited++;
		end
		confirm(chip.rx_rd == chip.rx_wr, "host bytes were never read by the bridge");
		repeat (30) @(posedge CLK);
	endtask

	// ------------------------------------------------------------
	// Test file
	// ------------------------------------------------------------

	task automatic load_tests();
		int         fd;
		int         r;
		logic [7:0] kind;
		logic [8*160-1:0] line;
		int         v [0:8];
		int         k;
		fd = $fopen("sim/bridge_tests.txt", "r");
		if (fd == 0)
		begin
			$display("ERROR: cannot open sim/bridge_tests.txt");
			$display("Something failed");
			$finish;
		end
		else
		begin
			r = $fscanf(fd, " %c", kind);
			while (r == 1)
			begin
				for (k = 0; k < 9; k++)
					v[k] = 0;
				// Comment lines skipped whole
				if (kind == "#")
					r = $fgets(line, fd);
				else
				begin
					if (kind == "D")
						r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
							v[3], v[4], v[5], v[6], v[7], v[8]);
					else if (kind == "H")
						r = $fscanf(fd, "%h %h %h %h %h %h %d %h", v[0], v[1], v[2],
							v[3], v[4], v[5], v[6], v[7]);
					else
						r = $fscanf(fd, "%d", v[0]);
					confirm(kind == "D" || kind == "H" || kind == "R",
						"unknown record kind in the test file");
					rec_kind[n_rec] = kind;
					for (k = 0; k < 9; k++)
						rec_f[n_rec][k] = v[k];
					n_rec = n_rec + 1;
				end
				r = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
			tests_loaded = 1'b1;
		end
	endtask

	// ------------------------------------------------------------
	// Test kinds
	// ------------------------------------------------------------

	// Host bytes in, zero or one dev_strobe out
	task automatic host_pair_test(input int t);
		int base;
		int nexp;
		int k;
		int waited;
		base = strobe_count;
		nexp = rec_f[t][5];
		@(posedge CLK);
		#2;
		for (k = 0; k < rec_f[t][0]; k++)
			chip.push_byte(8'(rec_f[t][1 + k]));
		waited = 0;
		while (strobe_count < base + nexp && waited < 300)
		begin
			@(posedge CLK);
			waited++;
		end
		confirm(strobe_count >= base + nexp, "dev_strobe never came for the host pair");
		drain_and_settle();
		confirm(strobe_count <= base + nexp, "dev_strobe fired for bytes that must be dropped");
		if (nexp > 0 && strobe_count > base)
		begin
			compare_hex("dev_cmd", rec_f[t][6], got_cmd[base]);
			compare_hex("dev_addr", rec_f[t][7], got_addr[base]);
			compare_hex("dev_data", rec_f[t][8], got_data[base]);
		end
	endtask

	// Device request in, header and payload in the chip log
	task automatic device_msg_test(input int t);
		int base;
		int nexp;
		int stall;
		int waited;
		int seen;
		base  = chip.log_count;
		nexp  = rec_f[t][3];
		stall = rec_f[t][6];
		@(posedge CLK);
		#2;
		if (stall > 0)
			chip.hold_txe(stall);
		send_request(3'(rec_f[t][0]), 3'(rec_f[t][1]), 8'(rec_f[t][2]));
		// Second request lands while the first is in flight
		if (rec_f[t][7] != 0)
		begin
			confirm(busy === 1'b1, "busy low right after an accepted request");
			send_request(3'(rec_f[t][0]), 3'(rec_f[t][1] + 1), 8'(rec_f[t][2]) ^ 8'hff);
		end
		if (nexp == 0)
			confirm(busy === 1'b0, "busy rose for a request that must be ignored");
		seen   = base;
		waited = 0;
		while (chip.log_count < base + nexp && waited < 300 + stall)
		begin
			@(negedge CLK);
			confirm(!(usb_txe_n && chip.log_count != seen), "byte written while TXE was high");
			seen = chip.log_count;
			waited++;
		end
		confirm(chip.log_count >= base + nexp, "message bytes never reached the chip");
		if (nexp > 0)
			confirm(busy === 1'b1, "busy fell before the payload was written");
		wait_not_busy();
		repeat (10) @(posedge CLK);
		confirm(chip.log_count == base + nexp, "extra bytes reached the chip");
		if (nexp > 0 && chip.log_count >= base + 2)
		begin
			compare_hex("header", rec_f[t][4], chip.log_mem[base]);
			compare_hex("payload", rec_f[t][5], chip.log_mem[base + 1]);
		end
	endtask

	// Mixed host pairs and device messages from the LCG
	task automatic random_traffic(input int count);
		int         i;
		int         base_s;
		int         base_l;
		int         n_host;
		int         n_dev;
		int         waited;
		logic [7:0] r8;
		logic [2:0] c;
		logic [2:0] a;
		logic [7:0] d;
		logic [2:0] e_cmd  [0:63];
		logic [2:0] e_addr [0:63];
		logic [7:0] e_data [0:63];
		logic [7:0] e_log  [0:127];
		base_s = strobe_count;
		base_l = chip.log_count;
		n_host = 0;
		n_dev  = 0;
		for (i = 0; i < count; i++)
		begin
			r8 = rand_byte();
			c  = r8[0] ? 3'd2 : 3'd1;
			a  = 3'(rand_byte());
			d  = rand_byte();
			@(posedge CLK);
			#2;
			chip.push_byte({2'b10, c, a});
			chip.push_byte(d);
			e_cmd[n_host]  = c;
			e_addr[n_host] = (c == 3'd1) ? 3'd0 : a;
			e_data[n_host] = d;
			n_host++;
			// Device side waits for the encoder
			r8 = rand_byte();
			c  = r8[0] ? 3'd2 : 3'd1;
			a  = 3'(rand_byte());
			d  = rand_byte();
			wait_not_busy();
			send_request(c, a, d);
			e_log[n_dev]     = {2'b11, c, (c == 3'd1) ? 3'd0 : a};
			e_log[n_dev + 1] = d;
			n_dev += 2;
		end
		waited = 0;
		while ((strobe_count < base_s + n_host || chip.log_count < base_l + n_dev) &&
			waited < 150 * count + 300)
		begin
			@(posedge CLK);
			waited++;
		end
		drain_and_settle();
		confirm(strobe_count == base_s + n_host, "wrong number of dev_strobe pulses");
		confirm(chip.log_count == base_l + n_dev, "wrong number of bytes sent to the chip");
		for (i = 0; i < n_host && base_s + i < strobe_count; i++)
		begin
			compare_hex("dev_cmd", e_cmd[i], got_cmd[base_s + i]);
			compare_hex("dev_addr", e_addr[i], got_addr[base_s + i]);
			compare_hex("dev_data", e_data[i], got_data[base_s + i]);
		end
		for (i = 0; i < n_dev && base_l + i < chip.log_count; i++)
			compare_hex("usb_data", e_log[i], chip.log_mem[base_l + i]);
	endtask

	task automatic close_test(input int num, input logic [7:0] kind, input int e0);
		if (errors == e0)
		begin
			n_pass++;
			$display("test %0d %c: pass", num, kind);
		end
		else
		begin
			n_fail++;
			$display("test %0d %c: fail", num, kind);
		end
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------

	initial
	begin
		int t;
		int e0;
		host_req  = 1'b0;
		host_cmd  = cmd_e'(3'd0);
		host_addr = 3'd0;
		host_data = 8'h00;
		RST_N     = 1'b0;
		load_tests();
		repeat (16) @(posedge CLK);
		#2;
		RST_N = 1'b1;

		// Idle pins and outputs after reset
		e0 = errors;
		@(negedge CLK);
		compare_hex("usb_rd_n", 1'b1, usb_rd_n);
		compare_hex("usb_wr_n", 1'b1, usb_wr_n);
		confirm(usb_data === 8'hzz, "usb_data is driven after reset");
		compare_hex("dev_strobe", 1'b0, dev_strobe);
		compare_hex("busy", 1'b0, busy);
		close_test(0, "Z", e0);

		for (t = 0; t < n_rec; t++)
		begin
			e0 = errors;
			if (rec_kind[t] == "D")
				host_pair_test(t);
			else if (rec_kind[t] == "H")
				device_msg_test(t);
			else
				random_traffic(rec_f[t][0]);
			close_test(t + 1, rec_kind[t], e0);
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			n_pass + n_fail, n_pass, n_fail, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: sim/bridge_tests.txt
# D count b0 b1 b2 b3 strobes cmd addr data       (all hex, unused bytes 00)
# H cmd addr data nbytes header payload stall dup (stall decimal)   R count (decimal)
D 2 8d 5a 00 00 1 1 0 5a
D 2 93 c3 00 00 1 2 3 c3
D 2 97 00 00 00 1 2 7 00
D 3 3c 92 a5 00 1 2 2 a5
D 3 e9 89 77 00 1 1 0 77
D 4 99 42 8a 11 1 1 0 11
D 2 84 55 00 00 0 0 0 00
D 2 b8 8c 00 00 0 0 0 00
D 1 17 00 00 00 0 0 0 00
H 1 5 3e 2 c8 3e 0 0
H 2 6 81 2 d6 81 0 0
H 2 1 44 2 d1 44 0 1
H 5 2 99 0 00 00 0 0
H 0 3 12 0 00 00 0 0
H 2 7 f0 2 d7 f0 25 0
H 1 3 0f 2 c8 0f 60 0
H 1 4 a0 2 c8 a0 30 1
R 6
R 8

// File: filelist.f
hdl/usb_bridge_pkg.sv
hdl/usb_byte_if.sv
hdl/ft245_port.sv
hdl/host_cmd_decoder.sv
hdl/device_msg_encoder.sv
hdl/usb_fifo_bridge.sv
sim/ft245_chip_model.sv
sim/tb_usb_fifo_bridge.sv
